// File: run_sim.sh
#!/usr/bin/env bash
# build the core and its testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cpu_tb -o cpu_tb_sim \
	&& ./obj_dir/cpu_tb_sim | tee sim.log \
	|| { echo "build or simulation run failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1

// File: src/cpu_top.sv
`timescale 1ns/100ps

module cpu_top #(
	parameter int XLEN     = 32,
	parameter int NUM_REGS = 32
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic [XLEN-1:0]                       i_pc_rddata,
	input  logic [XLEN-1:0]                       i_ldst_rddata,
	output logic [XLEN-1:0]                       o_pc_addr,
	output logic                                  o_pc_rd,
	output logic [mem_access_pkg::BYTE_LANES-1:0] o_pc_byte_en,
	output logic [XLEN-1:0]                       o_ldst_addr,
	output logic                                  o_ldst_rd,
	output logic                                  o_ldst_wr,
	output logic [XLEN-1:0]                       o_ldst_wrdata,
	output logic [mem_access_pkg::BYTE_LANES-1:0] o_ldst_byte_en,
	output logic [XLEN-1:0]                       o_tb_regs [NUM_REGS]
);
	import rv_isa_pkg::*;
	import mem_access_pkg::*;

	localparam int IDX_W = $clog2(NUM_REGS);

	// decode stage
	logic                dec_valid;
	logic [OPCODE_W-1:0] dec_opcode;
	logic [FUNCT3_W-1:0] dec_funct3;
	logic [FUNCT7_W-1:0] dec_funct7;
	logic [IDX_W-1:0]    dec_rs1;
	logic [IDX_W-1:0]    dec_rs2;
	logic [IDX_W-1:0]    dec_rd;
	logic [XLEN-1:0]     dec_imm;

	// register reads and forwarded operands
	logic [IDX_W-1:0]    rs1_addr;
	logic [IDX_W-1:0]    rs2_addr;
	logic [XLEN-1:0]     rs1_data;
	logic [XLEN-1:0]     rs2_data;
	logic [XLEN-1:0]     fwd_rs1_val;
	logic [XLEN-1:0]     fwd_rs2_val;

	// execute stage
	logic                ex_valid;
	logic [OPCODE_W-1:0] ex_opcode;
	logic [FUNCT3_W-1:0] ex_funct3;
	logic [IDX_W-1:0]    ex_rd;
	logic                ex_writes;
	logic [XLEN-1:0]     ex_result;

	// write back
	logic                wb_en;
	logic [IDX_W-1:0]    wb_addr;
	logic [XLEN-1:0]     wb_data;

	// instruction reads are always whole words
	assign o_pc_byte_en = BE_WORD;

	fetch_decode #(
		.XLEN     (XLEN),
		.NUM_REGS (NUM_REGS)
	) u_fetch_decode (
		.clk          (clk),
		.reset        (reset),
		.i_pc_rddata  (i_pc_rddata),
		.o_pc_addr    (o_pc_addr),
		.o_pc_rd      (o_pc_rd),
		.o_dec_valid  (dec_valid),
		.o_dec_opcode (dec_opcode),
		.o_dec_funct3 (dec_funct3),
		.o_dec_funct7 (dec_funct7),
		.o_dec_rs1    (dec_rs1),
		.o_dec_rs2    (dec_rs2),
		.o_dec_rd     (dec_rd),
		.o_dec_imm    (dec_imm)
	);

	reg_file #(
		.XLEN     (XLEN),
		.NUM_REGS (NUM_REGS)
	) u_reg_file (
		.clk        (clk),
		.reset      (reset),
		.i_rs1_addr (rs1_addr),
		.i_rs2_addr (rs2_addr),
		.i_wr_en    (wb_en),
		.i_wr_addr  (wb_addr),
		.i_wr_data  (wb_data),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data),
		.o_regs     (o_tb_regs)
	);

	exec_unit #(
		.XLEN     (XLEN),
		.NUM_REGS (NUM_REGS)
	) u_exec_unit (
		.clk          (clk),
		.reset        (reset),
		.i_dec_valid  (dec_valid),
		.i_dec_opcode (dec_opcode),
		.i_dec_funct3 (dec_funct3),
		.i_dec_funct7 (dec_funct7),
		.i_dec_rs1    (dec_rs1),
		.i_dec_rs2    (dec_rs2),
		.i_dec_rd     (dec_rd),
		.i_dec_imm    (dec_imm),
		.i_rs1_data   (rs1_data),
		.i_rs2_data   (rs2_data),
		.o_rs1_addr   (rs1_addr),
		.o_rs2_addr   (rs2_addr),
		.o_fwd_rs1    (fwd_rs1_val),
		.o_fwd_rs2    (fwd_rs2_val),
		.o_ex_valid   (ex_valid),
		.o_ex_opcode  (ex_opcode),
		.o_ex_funct3  (ex_funct3),
		.o_ex_rd      (ex_rd),
		.o_ex_writes  (ex_writes),
		.o_ex_result  (ex_result)
	);

	load_store_unit #(
		.XLEN     (XLEN),
		.NUM_REGS (NUM_REGS)
	) u_load_store_unit (
		.clk            (clk),
		.reset          (reset),
		.i_dec_valid    (dec_valid),
		.i_dec_opcode   (dec_opcode),
		.i_dec_funct3   (dec_funct3),
		.i_dec_imm      (dec_imm),
		.i_fwd_rs1      (fwd_rs1_val),
		.i_fwd_rs2      (fwd_rs2_val),
		.i_ex_valid     (ex_valid),
		.i_ex_opcode    (ex_opcode),
		.i_ex_funct3    (ex_funct3),
		.i_ex_rd        (ex_rd),
		.i_ex_writes    (ex_writes),
		.i_ex_result    (ex_result),
		.i_ldst_rddata  (i_ldst_rddata),
		.o_ldst_addr    (o_ldst_addr),
		.o_ldst_rd      (o_ldst_rd),
		.o_ldst_wr      (o_ldst_wr),
		.o_ldst_wrdata  (o_ldst_wrdata),
		.o_ldst_byte_en (o_ldst_byte_en),
		.o_wb_en        (wb_en),
		.o_wb_addr      (wb_addr),
		.o_wb_data      (wb_data)
	);

endmodule

// File: src/exec_unit.sv
`timescale 1ns/100ps

module exec_unit #(
	parameter int XLEN     = 32,
	parameter int NUM_REGS = 32
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            i_dec_valid,
	input  logic [rv_isa_pkg::OPCODE_W-1:0] i_dec_opcode,
	input  logic [rv_isa_pkg::FUNCT3_W-1:0] i_dec_funct3,
	input  logic [rv_isa_pkg::FUNCT7_W-1:0] i_dec_funct7,
	input  logic [$clog2(NUM_REGS)-1:0]     i_dec_rs1,
	input  logic [$clog2(NUM_REGS)-1:0]     i_dec_rs2,
	input  logic [$clog2(NUM_REGS)-1:0]     i_dec_rd,
	input  logic [XLEN-1:0]                 i_dec_imm,
	input  logic [XLEN-1:0]                 i_rs1_data,
	input  logic [XLEN-1:0]                 i_rs2_data,
	output logic [$clog2(NUM_REGS)-1:0]     o_rs1_addr,
	output logic [$clog2(NUM_REGS)-1:0]     o_rs2_addr,
	output logic [XLEN-1:0]                 o_fwd_rs1,
	output logic [XLEN-1:0]                 o_fwd_rs2,
	output logic                            o_ex_valid,
	output logic [rv_isa_pkg::OPCODE_W-1:0] o_ex_opcode,
	output logic [rv_isa_pkg::FUNCT3_W-1:0] o_ex_funct3,
	output logic [$clog2(NUM_REGS)-1:0]     o_ex_rd,
	output logic                            o_ex_writes,
	output logic [XLEN-1:0]                 o_ex_result
);
	import rv_isa_pkg::*;

	logic                   fwd_hit1;
	logic                   fwd_hit2;
	logic [XLEN-1:0]        op_a;
	logic [XLEN-1:0]        op_b;
	logic [4:0]             shamt;
	logic                   alt;
	logic signed [XLEN-1:0] sra_val;
	logic [XLEN-1:0]        alu_val;
	logic [XLEN-1:0]        ex_next;

	assign o_rs1_addr = i_dec_rs1;
	assign o_rs2_addr = i_dec_rs2;

	// bypass from the instruction one stage ahead
	// o_ex_writes is already low for rd zero
	assign fwd_hit1  = o_ex_valid && o_ex_writes && (o_ex_rd == i_dec_rs1);
	assign fwd_hit2  = o_ex_valid && o_ex_writes && (o_ex_rd == i_dec_rs2);
	assign o_fwd_rs1 = fwd_hit1 ? o_ex_result : i_rs1_data;
	assign o_fwd_rs2 = fwd_hit2 ? o_ex_result : i_rs2_data;

	assign op_a    = o_fwd_rs1;
	assign op_b    = (i_dec_opcode == OP_R) ? o_fwd_rs2 : i_dec_imm;
	assign shamt   = op_b[4:0];
	assign alt     = (i_dec_funct7 == F7_ALT);
	assign sra_val = $signed(op_a) >>> shamt;

	always_comb begin
		case (i_dec_funct3)
			// addi never subtracts
			F3_ADD_SUB: alu_val = (i_dec_opcode == OP_R && alt) ? op_a - op_b : op_a + op_b;
			F3_SLL:     alu_val = op_a << shamt;
			F3_SLT:     alu_val = XLEN'($signed(op_a) < $signed(op_b));
			F3_SLTU:    alu_val = XLEN'(op_a < op_b);
			F3_XOR:     alu_val = op_a ^ op_b;
			F3_SR:      alu_val = alt ? sra_val : op_a >> shamt;
			F3_OR:      alu_val = op_a | op_b;
			F3_AND:     alu_val = op_a & op_b;
		endcase
	end

	// loads and stores leave their address here
	always_comb begin
		case (i_dec_opcode)
			OP_LUI:       ex_next = i_dec_imm;
			OP_R, OP_IMM: ex_next = alu_val;
			default:      ex_next = op_a + op_b;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_ex_valid <= 1'b0;
		end else begin
			o_ex_valid <= i_dec_valid;
		end
	end

	always_ff @(posedge clk) begin
		o_ex_opcode <= i_dec_opcode;
		o_ex_funct3 <= i_dec_funct3;
		o_ex_rd     <= i_dec_rd;
		o_ex_writes <= (i_dec_opcode != OP_STORE) && (i_dec_rd != '0);
		o_ex_result <= ex_next;
	end

endmodule

// File: src/fetch_decode.sv
`timescale 1ns/100ps

module fetch_decode #(
	parameter int XLEN     = 32,
	parameter int NUM_REGS = 32
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [XLEN-1:0]                 i_pc_rddata,
	output logic [XLEN-1:0]                 o_pc_addr,
	output logic                            o_pc_rd,
	output logic                            o_dec_valid,
	output logic [rv_isa_pkg::OPCODE_W-1:0] o_dec_opcode,
	output logic [rv_isa_pkg::FUNCT3_W-1:0] o_dec_funct3,
	output logic [rv_isa_pkg::FUNCT7_W-1:0] o_dec_funct7,
	output logic [$clog2(NUM_REGS)-1:0]     o_dec_rs1,
	output logic [$clog2(NUM_REGS)-1:0]     o_dec_rs2,
	output logic [$clog2(NUM_REGS)-1:0]     o_dec_rd,
	output logic [XLEN-1:0]                 o_dec_imm
);
	import rv_isa_pkg::*;
	import mem_access_pkg::*;

	localparam int IDX_W   = $clog2(NUM_REGS);
	localparam int ALIGN_W = $clog2(BYTE_LANES);

	logic [XLEN-1:0]     pc;
	logic                fetch_en;
	logic                rd_pending;
	instr_fmt_u          instr;
	logic                known_op;
	logic                shift_imm;
	logic [FUNCT7_W-1:0] funct7;
	logic [XLEN-1:0]     imm;

	assign instr     = i_pc_rddata[31:0];
	assign o_pc_addr = pc;
	assign o_pc_rd   = fetch_en;

	// fetch starts one cycle after reset drops, memory answers a cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			pc          <= '0;
			fetch_en    <= 1'b0;
			rd_pending  <= 1'b0;
			o_dec_valid <= 1'b0;
		end else begin
			fetch_en    <= 1'b1;
			rd_pending  <= fetch_en;
			o_dec_valid <= rd_pending && known_op;
			if (fetch_en) begin
				pc <= pc + XLEN'(BYTE_LANES);
			end
		end
	end

	assign known_op = (instr.r_fmt.opcode == OP_R) || (instr.r_fmt.opcode == OP_IMM) ||
		(instr.r_fmt.opcode == OP_LOAD) || (instr.r_fmt.opcode == OP_STORE) ||
		(instr.r_fmt.opcode == OP_LUI);

	// srai carries its alt bit in the upper immediate
	assign shift_imm = (instr.i_fmt.opcode == OP_IMM) && (instr.i_fmt.funct3 == F3_SR);
	assign funct7 = (instr.r_fmt.opcode == OP_R || shift_imm) ? instr.r_fmt.funct7 : F7_BASE;

	always_comb begin
		case (instr.r_fmt.opcode)
			OP_STORE: imm = {{(XLEN-12){instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi,
				instr.s_fmt.imm_lo};
			OP_LUI:   imm = XLEN'({instr.u_fmt.imm, 12'b0});
			default:  imm = {{(XLEN-12){instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
		endcase
	end

	// decoded fields, qualified by o_dec_valid
	always_ff @(posedge clk) begin
		o_dec_opcode <= instr.r_fmt.opcode;
		o_dec_funct3 <= instr.r_fmt.funct3;
		o_dec_funct7 <= funct7;
		o_dec_rs1    <= instr.r_fmt.rs1[IDX_W-1:0];
		o_dec_rs2    <= instr.r_fmt.rs2[IDX_W-1:0];
		o_dec_rd     <= instr.r_fmt.rd[IDX_W-1:0];
		o_dec_imm    <= imm;
	end

	// fetch addresses stay word aligned
	assert property (@(posedge clk) disable iff (reset)
		o_pc_rd |-> (o_pc_addr[ALIGN_W-1:0] == '0));

endmodule

// File: src/load_store_unit.sv
`timescale 1ns/100ps

module load_store_unit #(
	parameter int XLEN     = 32,
	parameter int NUM_REGS = 32
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                i_dec_valid,
	input  logic [rv_isa_pkg::OPCODE_W-1:0]     i_dec_opcode,
	input  logic [rv_isa_pkg::FUNCT3_W-1:0]     i_dec_funct3,
	input  logic [XLEN-1:0]                     i_dec_imm,
	input  logic [XLEN-1:0]                     i_fwd_rs1,
	input  logic [XLEN-1:0]                     i_fwd_rs2,
	input  logic                                i_ex_valid,
	input  logic [rv_isa_pkg::OPCODE_W-1:0]     i_ex_opcode,
	input  logic [rv_isa_pkg::FUNCT3_W-1:0]     i_ex_funct3,
	input  logic [$clog2(NUM_REGS)-1:0]         i_ex_rd,
	input  logic                                i_ex_writes,
	input  logic [XLEN-1:0]                     i_ex_result,
	input  logic [XLEN-1:0]                     i_ldst_rddata,
	output logic [XLEN-1:0]                     o_ldst_addr,
	output logic                                o_ldst_rd,
	output logic                                o_ldst_wr,
	output logic [XLEN-1:0]                     o_ldst_wrdata,
	output logic [mem_access_pkg::BYTE_LANES-1:0] o_ldst_byte_en,
	output logic                                o_wb_en,
	output logic [$clog2(NUM_REGS)-1:0]         o_wb_addr,
	output logic [XLEN-1:0]                     o_wb_data
);
	import rv_isa_pkg::*;
	import mem_access_pkg::*;

	logic                  is_load;
	logic                  is_store;
	logic [XLEN-1:0]       load_val;

	// strobes come out in the execute cycle
	assign is_load     = i_dec_valid && (i_dec_opcode == OP_LOAD);
	assign is_store    = i_dec_valid && (i_dec_opcode == OP_STORE);
	assign o_ldst_rd   = is_load;
	assign o_ldst_wr   = is_store;
	assign o_ldst_addr = i_fwd_rs1 + i_dec_imm;

	// byte enables follow the access size, loads and stores alike
	always_comb begin
		case (i_dec_funct3)
			F3_LB, F3_LBU: o_ldst_byte_en = BE_BYTE;
			F3_LH, F3_LHU: o_ldst_byte_en = BE_HALF;
			default:       o_ldst_byte_en = BE_WORD;
		endcase
	end

	// store data masked to its size
	always_comb begin
		case (i_dec_funct3)
			F3_SB:   o_ldst_wrdata = XLEN'(i_fwd_rs2[7:0]);
			F3_SH:   o_ldst_wrdata = XLEN'(i_fwd_rs2[15:0]);
			default: o_ldst_wrdata = i_fwd_rs2;
		endcase
	end

	// load data shows up in the write-back cycle
	always_comb begin
		case (i_ex_funct3)
			F3_LB:   load_val = {{(XLEN-8){i_ldst_rddata[7]}}, i_ldst_rddata[7:0]};
			F3_LH:   load_val = {{(XLEN-16){i_ldst_rddata[15]}}, i_ldst_rddata[15:0]};
			F3_LBU:  load_val = XLEN'(i_ldst_rddata[7:0]);
			F3_LHU:  load_val = XLEN'(i_ldst_rddata[15:0]);
			default: load_val = i_ldst_rddata;
		endcase
	end

	assign o_wb_en   = i_ex_valid && i_ex_writes;
	assign o_wb_addr = i_ex_rd;
	assign o_wb_data = (i_ex_opcode == OP_LOAD) ? load_val : i_ex_result;

	assert property (@(posedge clk) disable iff (reset) !(o_ldst_rd && o_ldst_wr));

endmodule

// File: src/mem_access_pkg.sv
package mem_access_pkg;

	// byte lanes in one memory word
	localparam int BYTE_LANES = 4;

	// load sizes, funct3 of a load
	localparam logic [2:0] F3_LB  = 3'h0;
	localparam logic [2:0] F3_LH  = 3'h1;
	localparam logic [2:0] F3_LW  = 3'h2;
	localparam logic [2:0] F3_LBU = 3'h4;
	localparam logic [2:0] F3_LHU = 3'h5;

	// store sizes, funct3 of a store
	localparam logic [2:0] F3_SB = 3'h0;
	localparam logic [2:0] F3_SH = 3'h1;
	localparam logic [2:0] F3_SW = 3'h2;

	// sub-word data sits in the low lanes
	localparam logic [BYTE_LANES-1:0] BE_BYTE = 4'b0001;
	localparam logic [BYTE_LANES-1:0] BE_HALF = 4'b0011;
	localparam logic [BYTE_LANES-1:0] BE_WORD = 4'b1111;

endpackage

// File: src/reg_file.sv
`timescale 1ns/100ps

module reg_file #(
	parameter int XLEN     = 32,
	parameter int NUM_REGS = 32
) (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [$clog2(NUM_REGS)-1:0] i_rs1_addr,
	input  logic [$clog2(NUM_REGS)-1:0] i_rs2_addr,
	input  logic                        i_wr_en,
	input  logic [$clog2(NUM_REGS)-1:0] i_wr_addr,
	input  logic [XLEN-1:0]             i_wr_data,
	output logic [XLEN-1:0]             o_rs1_data,
	output logic [XLEN-1:0]             o_rs2_data,
	output logic [XLEN-1:0]             o_regs [NUM_REGS]
);

	logic [XLEN-1:0] regs [NUM_REGS];

	// x0 is never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wr_en && i_wr_addr != '0) begin
			regs[i_wr_addr] <= i_wr_data;
		end
	end

	// combinational reads
	assign o_rs1_data = regs[i_rs1_addr];
	assign o_rs2_data = regs[i_rs2_addr];
	assign o_regs     = regs;

	// entry zero stays zero
	assert property (@(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

// File: src/rv_isa_pkg.sv
package rv_isa_pkg;

	// field widths carried on the decode and execute ports
	localparam int OPCODE_W = 7;
	localparam int FUNCT3_W = 3;
	localparam int FUNCT7_W = 7;

	// opcodes handled by the core
	localparam logic [OPCODE_W-1:0] OP_R     = 7'b0110011;
	localparam logic [OPCODE_W-1:0] OP_IMM   = 7'b0010011;
	localparam logic [OPCODE_W-1:0] OP_LOAD  = 7'b0000011;
	localparam logic [OPCODE_W-1:0] OP_STORE = 7'b0100011;
	localparam logic [OPCODE_W-1:0] OP_LUI   = 7'b0110111;

	// alu funct3 codes, shared by R and I forms
	localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'h0;
	localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'h1;
	localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'h2;
	localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'h3;
	localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'h4;
	localparam logic [FUNCT3_W-1:0] F3_SR      = 3'h5;
	localparam logic [FUNCT3_W-1:0] F3_OR      = 3'h6;
	localparam logic [FUNCT3_W-1:0] F3_AND     = 3'h7;

	// alt picks sub and sra
	localparam logic [FUNCT7_W-1:0] F7_BASE = 7'h00;
	localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'h20;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// one instruction word seen through each format
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		u_fmt_t u_fmt;
	} instr_fmt_u;

endpackage

// File: tb/clock_gen.sv
`timescale 1ns/100ps

module clock_gen #(
	parameter int PERIOD_NS = 20
) (
	output logic o_clk
);

	// free running, starts low
	initial begin
		o_clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) o_clk = ~o_clk;
		end
	end

endmodule

// File: tb/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

	localparam int    XLEN       = 32;
	localparam int    NUM_REGS   = 32;
	localparam int    MAX_CYCLES = 1000;
	localparam int    DRAIN      = 4;
	localparam string INPUT_FILE = "tb/program_input.txt";

	logic            clk;
	logic            reset;
	logic [XLEN-1:0] pc_rddata;
	logic [XLEN-1:0] ldst_rddata;
	logic [XLEN-1:0] pc_addr;
	logic            pc_rd;
	logic [3:0]      pc_byte_en;
	logic [XLEN-1:0] ldst_addr;
	logic            ldst_rd;
	logic            ldst_wr;
	logic [XLEN-1:0] ldst_wrdata;
	logic [3:0]      ldst_byte_en;
	logic [XLEN-1:0] tb_regs [NUM_REGS];

	// memory images and expected results, filled from the input file
	logic [XLEN-1:0] imem [logic [XLEN-1:0]];
	logic [XLEN-1:0] dmem [logic [XLEN-1:0]];
	logic [XLEN-1:0] exp_regs [NUM_REGS];
	logic [XLEN-1:0] exp_st_addr [$];
	logic [XLEN-1:0] exp_st_data [$];
	logic [3:0]      exp_st_be [$];
	int              prog_words;
	int              checks;
	int              errors;
	int              cycles_out_of_reset;
	logic            reached_end;

	clock_gen #(.PERIOD_NS(20)) u_clock_gen (.o_clk(clk));

	cpu_top #(
		.XLEN     (XLEN),
		.NUM_REGS (NUM_REGS)
	) UUT (
		.clk            (clk),
		.reset          (reset),
		.i_pc_rddata    (pc_rddata),
		.i_ldst_rddata  (ldst_rddata),
		.o_pc_addr      (pc_addr),
		.o_pc_rd        (pc_rd),
		.o_pc_byte_en   (pc_byte_en),
		.o_ldst_addr    (ldst_addr),
		.o_ldst_rd      (ldst_rd),
		.o_ldst_wr      (ldst_wr),
		.o_ldst_wrdata  (ldst_wrdata),
		.o_ldst_byte_en (ldst_byte_en),
		.o_tb_regs      (tb_regs)
	);

	function automatic logic [XLEN-1:0] word_addr(input logic [XLEN-1:0] addr);
		return {addr[XLEN-1:2], 2'b00};
	endfunction

	// data words never written by the file or a store
	function automatic logic [XLEN-1:0] unwritten_word(input logic [XLEN-1:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h5A5A_A5A5;
	endfunction

	task automatic compare_value(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, expected);
		end
	endtask

	task automatic load_input();
		int              fd;
		int              n;
		string           line;
		string           rest;
		logic [7:0]      kind;
		logic [XLEN-1:0] f1;
		logic [XLEN-1:0] f2;
		logic [XLEN-1:0] f3;
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			errors++;
			$display("ERROR: cannot open %s", INPUT_FILE);
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 2) begin
				kind = line.getc(0);
				rest = line.substr(2, line.len() - 1);
				n = $sscanf(rest, "%h %h %h", f1, f2, f3);
				case (kind)
					"#": begin
					end
					"P": begin
						imem[XLEN'(prog_words * 4)] = f1;
						prog_words++;
					end
					"D": dmem[word_addr(f1)] = f2;
					"S": begin
						exp_st_addr.push_back(f1);
						exp_st_data.push_back(f2);
						exp_st_be.push_back(f3[3:0]);
					end
					"R": begin
						if (f1 < NUM_REGS) begin
							exp_regs[f1] = f2;
						end else begin
							errors++;
							$display("ERROR: register index %0d in %s is out of range", f1,
								INPUT_FILE);
						end
					end
					default: begin
						errors++;
						$display("ERROR: line of unknown kind in %s", INPUT_FILE);
					end
				endcase
			end
		end
		$fclose(fd);
	endtask

	task automatic check_strobes();
		if (ldst_rd && ldst_wr) begin
			errors++;
			$display("ERROR at %0d ns: load and store strobes are high together", $time);
		end
		// nothing may be strobed in reset or the cycle right after it
		if (cycles_out_of_reset <= 1 && (pc_rd || ldst_rd || ldst_wr)) begin
			errors++;
			$display("ERROR at %0d ns: a memory strobe is high during or right after reset",
				$time);
		end
		if (pc_rd) begin
			compare_value("o_pc_byte_en", XLEN'(pc_byte_en), XLEN'(4'b1111));
		end
	endtask

	task automatic check_store();
		if (exp_st_addr.size() == 0) begin
			errors++;
			$display("ERROR at %0d ns: unexpected store of %h to address %h", $time,
				ldst_wrdata, ldst_addr);
		end else begin
			compare_value("o_ldst_addr", ldst_addr, exp_st_addr.pop_front());
			compare_value("o_ldst_wrdata", ldst_wrdata, exp_st_data.pop_front());
			compare_value("o_ldst_byte_en", XLEN'(ldst_byte_en), XLEN'(exp_st_be.pop_front()));
		end
	endtask

	// merge the enabled lanes into the data memory
	task automatic write_store();
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] word;
		addr = word_addr(ldst_addr);
		word = dmem.exists(addr) ? dmem[addr] : unwritten_word(addr);
		for (int b = 0; b < 4; b++) begin
			if (ldst_byte_en[b]) begin
				word[8*b +: 8] = ldst_wrdata[8*b +: 8];
			end
		end
		dmem[addr] = word;
	endtask

	task automatic check_registers();
		for (int i = 0; i < NUM_REGS; i++) begin
			compare_value($sformatf("o_tb_regs[%0d]", i), tb_regs[i], exp_regs[i]);
		end
	endtask

	task automatic wait_for_pc(input logic [XLEN-1:0] end_addr, output logic reached);
		int cycles;
		cycles = 0;
		while (pc_addr < end_addr && cycles < MAX_CYCLES) begin
			@(negedge clk);
			cycles++;
		end
		reached = (pc_addr >= end_addr);
	endtask

	// requests sampled mid cycle, answered 1 ns after the next rising edge
	initial begin
		logic            fetch_req;
		logic [XLEN-1:0] fetch_addr;
		logic            load_req;
		logic [XLEN-1:0] load_addr;
		pc_rddata           = '0;
		ldst_rddata         = '0;
		cycles_out_of_reset = 0;
		forever begin
			@(negedge clk);
			if (reset) begin
				cycles_out_of_reset = 0;
			end else begin
				cycles_out_of_reset++;
			end
			fetch_req  = pc_rd;
			fetch_addr = word_addr(pc_addr);
			load_req   = ldst_rd;
			load_addr  = word_addr(ldst_addr);
			check_strobes();
			if (ldst_wr) begin
				check_store();
				write_store();
			end
			@(posedge clk);
			#1;
			if (fetch_req && imem.exists(fetch_addr)) begin
				pc_rddata = imem[fetch_addr];
			end else begin
				pc_rddata = '0;
			end
			if (!load_req) begin
				ldst_rddata = '0;
			end else if (dmem.exists(load_addr)) begin
				ldst_rddata = dmem[load_addr];
			end else begin
				ldst_rddata = unwritten_word(load_addr);
			end
		end
	end

	initial begin
		reset       = 1'b1;
		checks      = 0;
		errors      = 0;
		prog_words  = 0;
		reached_end = 1'b0;
		for (int i = 0; i < NUM_REGS; i++) begin
			exp_regs[i] = '0;
		end
		load_input();
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		wait_for_pc(XLEN'(prog_words * 4), reached_end);
		if (reached_end) begin
			// last instruction still has to pass execute and write back
			repeat (DRAIN) @(posedge clk);
			@(negedge clk);
			check_registers();
			if (exp_st_addr.size() != 0) begin
				errors++;
				$display("ERROR: %0d expected stores never happened", exp_st_addr.size());
			end
		end else begin
			errors++;
			$display("ERROR: timeout, the PC did not pass %h within %0d cycles",
				prog_words * 4, MAX_CYCLES);
		end
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: tb/program_input.txt
# kind and hex fields: P word | D addr word | S addr data byte_en | R reg value
# program words load at 0, 4, 8 in file order; text after the fields is ignored
P 800000B7  # lui  x1, 0x80000
P FFB00113  # addi x2, x0, -5
P 00C10193  # addi x3, x2, 12     rs1 forwarded
P 40218233  # sub  x4, x3, x2     x3 forwarded, x2 from the register file
P 4030D2B3  # sra  x5, x1, x3
P 003123B3  # slt  x7, x2, x3
P 00313433  # sltu x8, x2, x3
P 0F014493  # xori x9, x2, 0x0f0
P 40115513  # srai x10, x2, 1
P 00419593  # slli x11, x3, 4
P 03C5F613  # andi x12, x11, 0x03c
P 004666B3  # or   x13, x12, x4
P 00518013  # addi x0, x3, 5
P 10000793  # addi x15, x0, 0x100
P 00078803  # lb   x16, 0(x15)
P 0007C883  # lbu  x17, 0(x15)
P 00479903  # lh   x18, 4(x15)
P 0047D983  # lhu  x19, 4(x15)
P 0087AA03  # lw   x20, 8(x15)
P 0047A823  # sw   x4, 16(x15)
P 00978A23  # sb   x9, 20(x15)
P 01079C23  # sh   x16, 24(x15)
P 012A0AB3  # add  x21, x20, x18
P FF57AE23  # sw   x21, -4(x15)   store data forwarded
D 00000100 876543A1
D 00000104 1234F00D
D 00000108 5A3C96E1
S 00000110 0000000C F
S 00000114 0000000B 1
S 00000118 0000FFA1 3
S 000000FC 5A3C86EE F
R 00 00000000
R 01 80000000
R 02 FFFFFFFB
R 03 00000007
R 04 0000000C
R 05 FF000000
R 07 00000001
R 08 00000000
R 09 FFFFFF0B
R 0A FFFFFFFD
R 0B 00000070
R 0C 00000030
R 0D 0000003C
R 0F 00000100
R 10 FFFFFFA1
R 11 000000A1
R 12 FFFFF00D
R 13 0000F00D
R 14 5A3C96E1
R 15 5A3C86EE

// File: vlog.f
src/rv_isa_pkg.sv
src/mem_access_pkg.sv
src/fetch_decode.sv
src/reg_file.sv
src/exec_unit.sv
src/load_store_unit.sv
src/cpu_top.sv
tb/clock_gen.sv
tb/cpu_tb.sv
